//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = video_subsys_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
logic/video_pkg.sv
logic/frame_mem.sv
logic/mem_arbiter.sv
logic/pixel_fifo.sv
logic/pixel_feeder.sv
logic/fill_engine.sv
logic/video_subsys.sv
sim/video_subsys_tb.sv

//--- logic/fill_engine.sv
module fill_engine (
    input  logic                 cpu_clk_g,
    input  logic                 rst,
    input  video_pkg::fill_cmd_t cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    output video_pkg::wb_req_t   fill_req,
    input  video_pkg::wb_rsp_t   fill_rsp,
    output logic                 fill_done
);
    import video_pkg::*;

    fill_state_t       state;
    logic              done_q;
    pixel_t            color_q;
    logic [wcol_w-1:0] col0_q;              // left edge, reloaded each row
    logic [wcol_w-1:0] col_q;
    logic [row_w-1:0]  row_q;
    logic [wcol_w-1:0] last_col_q;
    logic [row_w-1:0]  last_row_q;
    logic [3:0]        col_end;             // unclipped inclusive ends
    logic [3:0]        row_end;
    logic [wcol_w-1:0] last_col;
    logic [row_w-1:0]  last_row;
    logic              cmd_empty;
    logic              accept;
    logic              last_word;

    // clip against the frame edges at capture
    always_comb begin
        col_end   = 4'(cmd.col0) + 4'(cmd.ncols) - 4'd1;
        row_end   = 4'(cmd.row0) + 4'(cmd.nrows) - 4'd1;
        cmd_empty = (cmd.ncols == 3'd0) || (cmd.nrows == 3'd0) ||
                    (4'(cmd.row0) >= 4'(frame_h));
        last_col  = (col_end > 4'(words_per_line - 1)) ? wcol_w'(words_per_line - 1)
                                                      : col_end[wcol_w-1:0];
        last_row  = (row_end > 4'(frame_h - 1)) ? row_w'(frame_h - 1)
                                                : row_end[row_w-1:0];
    end

    assign cmd_ready = (state == fill_idle);
    assign accept    = cmd_valid && cmd_ready;
    assign last_word = (col_q == last_col_q) && (row_q == last_row_q);

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            state  <= fill_idle;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                fill_idle: begin
                    if (accept) begin
                        if (cmd_empty) begin
                            done_q <= 1'b1;     // nothing to draw
                        end else begin
                            state <= fill_write;
                        end
                    end
                end
                fill_write: state <= fill_wait;   // request goes up
                fill_wait: begin
                    if (fill_rsp.ack) begin
                        if (last_word) begin
                            state  <= fill_idle;
                            done_q <= 1'b1;
                        end else begin
                            state <= fill_next;
                        end
                    end
                end
                fill_next: state <= fill_write;   // cyc low, bus free for one cycle
                default:   state <= fill_idle;
            endcase
        end
    end

    // rectangle payload and row-major walk
    always_ff @(posedge cpu_clk_g) begin
        if (accept) begin
            color_q    <= cmd.color;
            col0_q     <= cmd.col0;
            col_q      <= cmd.col0;
            row_q      <= cmd.row0[row_w-1:0];
            last_col_q <= last_col;
            last_row_q <= last_row;
        end else if (state == fill_next) begin
            if (col_q == last_col_q) begin
                col_q <= col0_q;
                row_q <= row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    always_comb begin
        fill_req       = '0;
        fill_req.cyc   = (state == fill_write) || (state == fill_wait);
        fill_req.stb   = fill_req.cyc;
        fill_req.we    = 1'b1;
        fill_req.adr   = {row_q, col_q};                        // row * words_per_line + col
        fill_req.dat_w = {pix_per_word{8'h00, color_q}};        // same colour in every lane
    end

    assign fill_done = done_q;

    // bus was released before each write, so no ack can land in the first cycle
    no_early_ack: assert property (
        @(posedge cpu_clk_g) disable iff (rst)
        (state == fill_write) |-> !fill_rsp.ack
    );

endmodule

//--- logic/frame_mem.sv
module frame_mem (
    input  logic               cpu_clk_g,
    input  logic               rst,
    input  video_pkg::wb_req_t mem_req,
    output video_pkg::wb_rsp_t mem_rsp
);
    import video_pkg::*;

    logic [127:0] mem_q [frame_words];      // one word = four pixel lanes
    logic [127:0] dat_q;                    // registered read port
    logic         ack_q;
    logic         req_seen;

    assign req_seen = mem_req.cyc && mem_req.stb;

    // single ack per transfer and never two in a row
    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_seen && !ack_q;
        end
    end

    // read sampled on the edge that raises ack so data lines up with it
    // write commits at the end of the ack cycle
    always_ff @(posedge cpu_clk_g) begin
        dat_q <= mem_q[mem_req.adr];
        if (ack_q && req_seen && mem_req.we) begin
            mem_q[mem_req.adr] <= mem_req.dat_w;
        end
    end

    always_comb begin
        mem_rsp.ack   = ack_q;
        mem_rsp.dat_r = dat_q;
    end

    // read port and write both need the request held until its ack
    req_held: assert property (
        @(posedge cpu_clk_g) disable iff (rst)
        req_seen && !ack_q |=> req_seen && $stable(mem_req.adr) && $stable(mem_req.we)
                               && $stable(mem_req.dat_w)
    );

endmodule

//--- logic/mem_arbiter.sv
module mem_arbiter (
    input  logic               cpu_clk_g,
    input  logic               rst,
    input  video_pkg::wb_req_t feed_req,
    output video_pkg::wb_rsp_t feed_rsp,
    input  video_pkg::wb_req_t fill_req,
    output video_pkg::wb_rsp_t fill_rsp,
    output video_pkg::wb_req_t mem_req,
    input  video_pkg::wb_rsp_t mem_rsp
);
    import video_pkg::*;

    grant_t grant;                          // current bus owner

    // owner keeps the bus until it lowers cyc
    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            grant <= grant_none;
        end else begin
            case (grant)
                grant_none: begin
                    if (feed_req.cyc) begin
                        grant <= grant_feed;    // feeder wins a tie
                    end else if (fill_req.cyc) begin
                        grant <= grant_fill;
                    end
                end
                grant_feed: if (!feed_req.cyc) grant <= grant_none;
                grant_fill: if (!fill_req.cyc) grant <= grant_none;
                default:    grant <= grant_none;
            endcase
        end
    end

    // request mux with an idle bus when nobody owns it
    always_comb begin
        case (grant)
            grant_feed: mem_req = feed_req;
            grant_fill: mem_req = fill_req;
            default:    mem_req = '0;
        endcase
    end

    // ack steered to the owner only and read data fanned out to both
    always_comb begin
        feed_rsp.ack   = mem_rsp.ack && (grant == grant_feed);
        feed_rsp.dat_r = mem_rsp.dat_r;
        fill_rsp.ack   = mem_rsp.ack && (grant == grant_fill);
        fill_rsp.dat_r = mem_rsp.dat_r;
    end

    // an open transfer keeps its owner until the ack
    grant_held: assert property (
        @(posedge cpu_clk_g) disable iff (rst)
        mem_req.stb && !mem_rsp.ack |=> $stable(grant)
    );

    // memory ack must belong to the master that issued the request
    ack_to_owner: assert property (
        @(posedge cpu_clk_g) disable iff (rst)
        mem_rsp.ack |-> (grant != grant_none) && (grant == $past(grant))
    );

endmodule

//--- logic/pixel_feeder.sv
module pixel_feeder (
    input  logic               cpu_clk_g,
    input  logic               rst,
    input  logic               video_en,
    output video_pkg::wb_req_t feed_req,
    input  video_pkg::wb_rsp_t feed_rsp,
    output video_pkg::pixel_t  video,
    output logic               video_valid,
    input  logic               video_ready,
    output logic               frame_interrupt
);
    import video_pkg::*;

    feed_state_t       state;
    logic [adr_w-1:0]  addr_q;              // next word to fetch, raster order
    logic [pcol_w-1:0] col_q;               // pixel position of next transfer
    logic [row_w-1:0]  row_q;
    logic              started_q;           // prefill reached once
    logic              can_fetch;
    logic              fifo_wr;
    logic              xfer;
    logic              fifo_empty;
    logic [2:0]        word_count;
    logic              last_col;
    logic              last_row;

    // only checked with no read in flight
    assign can_fetch = video_en && (word_count < fifo_words);
    assign fifo_wr   = (state == feed_fetch) && feed_rsp.ack;

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            state  <= feed_idle;
            addr_q <= '0;
        end else begin
            case (state)
                feed_idle: if (can_fetch) state <= feed_fetch;
                feed_fetch: begin
                    if (feed_rsp.ack) begin
                        state  <= feed_wait;
                        addr_q <= (addr_q == adr_w'(frame_words - 1)) ? '0 : addr_q + 1'b1;
                    end
                end
                feed_wait: state <= can_fetch ? feed_fetch : feed_idle;
                default:   state <= feed_idle;
            endcase
        end
    end

    // stb drops after each ack, cyc stays only if another word fits
    always_comb begin
        feed_req       = '0;
        feed_req.cyc   = (state == feed_fetch) || ((state == feed_wait) && can_fetch);
        feed_req.stb   = (state == feed_fetch);
        feed_req.we    = 1'b0;                  // read only master
        feed_req.adr   = addr_q;
    end

    pixel_fifo fifo_i (
        .cpu_clk_g  (cpu_clk_g),
        .rst        (rst),
        .wr_en      (fifo_wr),
        .din        (feed_rsp.dat_r),
        .rd_en      (xfer),
        .dout       (video),
        .empty      (fifo_empty),
        .word_count (word_count)
    );

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            started_q <= 1'b0;
        end else if (video_en && (word_count >= prefill_words)) begin
            started_q <= 1'b1;
        end
    end

    assign video_valid = started_q && !fifo_empty;  // independent of ready
    assign xfer        = video_valid && video_ready;

    assign last_col = (col_q == pcol_w'(frame_w - 1));
    assign last_row = (row_q == row_w'(frame_h - 1));

    // raster position of the pixel at the fifo head
    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            col_q <= '0;
            row_q <= '0;
        end else if (xfer) begin
            col_q <= last_col ? '0 : col_q + 1'b1;
            if (last_col) begin
                row_q <= last_row ? '0 : row_q + 1'b1;
            end
        end
    end

    assign frame_interrupt = xfer && last_col && last_row;   // pixel 63 leaving

    // a stalled pixel stays put until taken
    hold_under_stall: assert property (
        @(posedge cpu_clk_g) disable iff (rst)
        video_valid && !video_ready |=> video_valid && $stable(video)
    );

endmodule

//--- logic/pixel_fifo.sv
module pixel_fifo (
    input  logic              cpu_clk_g,
    input  logic              rst,
    input  logic              wr_en,
    input  logic [127:0]      din,
    input  logic              rd_en,
    output video_pkg::pixel_t dout,
    output logic              empty,
    output logic [2:0]        word_count
);
    import video_pkg::*;

    logic [127:0]                    buf_q [fifo_words];
    logic [$clog2(fifo_words)-1:0]   wr_ptr;
    logic [$clog2(fifo_words)-1:0]   rd_ptr;
    logic [$clog2(pix_per_word)-1:0] lane;          // next pixel within head word
    logic [2:0]                      count;
    logic                            rd;
    logic                            pop;

    assign empty      = (count == 3'd0);
    assign word_count = count;                      // partly read head still counts
    assign rd         = rd_en && !empty;
    assign pop        = rd && (lane == ($clog2(pix_per_word))'(pix_per_word - 1));

    // lowest lane first, top byte of each lane dropped
    assign dout = buf_q[rd_ptr][32 * lane +: 24];

    always_ff @(posedge cpu_clk_g) begin
        if (wr_en) begin
            buf_q[wr_ptr] <= din;
        end
    end

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            lane   <= '0;
            count  <= 3'd0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                lane <= lane + 1'b1;                // wraps back to lane 0 on pop
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + 3'(wr_en) - 3'(pop);
        end
    end

    // feeder flow control must keep one slot free per fetch
    no_overflow: assert property (
        @(posedge cpu_clk_g) disable iff (rst)
        wr_en |-> word_count < fifo_words
    );

endmodule

//--- logic/video_pkg.sv
package video_pkg;

    // frame geometry, kept tiny for simulation
    localparam int frame_w        = 16;                        // pixels per line
    localparam int frame_h        = 4;                         // lines per frame
    localparam int pix_per_word   = 4;                         // 32-bit lanes per memory word
    localparam int words_per_line = frame_w / pix_per_word;
    localparam int frame_words    = words_per_line * frame_h;
    localparam int adr_w          = 4;                         // word address width

    // pixel buffering
    localparam int fifo_words     = 4;                         // fifo depth in words
    localparam int prefill_words  = 2;                         // words held before first pixel

    // counter widths
    localparam int pcol_w = 4;                                 // pixel column in a line
    localparam int wcol_w = 2;                                 // word column in a line
    localparam int row_w  = 2;                                 // line number

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [adr_w-1:0] adr;
        logic [127:0]     dat_w;
    } wb_req_t;

    // wishbone classic, slave to master
    typedef struct packed {
        logic         ack;
        logic [127:0] dat_r;
    } wb_rsp_t;

    // rectangle in word columns and lines
    typedef struct packed {
        logic [1:0] col0;
        logic [2:0] row0;
        logic [2:0] ncols;
        logic [2:0] nrows;
        pixel_t     color;
    } fill_cmd_t;

    typedef enum logic [1:0] {feed_idle, feed_fetch, feed_wait} feed_state_t;

    typedef enum logic [1:0] {fill_idle, fill_write, fill_wait, fill_next} fill_state_t;

    typedef enum logic [1:0] {grant_none, grant_feed, grant_fill} grant_t;

endpackage

//--- logic/video_subsys.sv
module video_subsys (
    input  logic                 cpu_clk_g,
    input  logic                 rst,
    input  logic                 video_en,
    input  video_pkg::fill_cmd_t cmd,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    output logic                 fill_done,
    output video_pkg::pixel_t    video,
    output logic                 video_valid,
    input  logic                 video_ready,
    output logic                 frame_interrupt
);
    import video_pkg::*;

    wb_req_t feed_req;                      // feeder, bus priority
    wb_rsp_t feed_rsp;
    wb_req_t fill_req;                      // fill engine
    wb_rsp_t fill_rsp;
    wb_req_t mem_req;                       // arbiter to frame memory
    wb_rsp_t mem_rsp;

    pixel_feeder feeder_i (
        .cpu_clk_g       (cpu_clk_g),
        .rst             (rst),
        .video_en        (video_en),
        .feed_req        (feed_req),
        .feed_rsp        (feed_rsp),
        .video           (video),
        .video_valid     (video_valid),
        .video_ready     (video_ready),
        .frame_interrupt (frame_interrupt)
    );

    fill_engine fill_i (
        .cpu_clk_g (cpu_clk_g),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .fill_req  (fill_req),
        .fill_rsp  (fill_rsp),
        .fill_done (fill_done)
    );

    mem_arbiter arb_i (
        .cpu_clk_g (cpu_clk_g),
        .rst       (rst),
        .feed_req  (feed_req),
        .feed_rsp  (feed_rsp),
        .fill_req  (fill_req),
        .fill_rsp  (fill_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    frame_mem mem_i (
        .cpu_clk_g (cpu_clk_g),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

endmodule

//--- sim/video_subsys_tb.sv
module video_subsys_tb;
    import video_pkg::*;

    localparam logic [31:0] lfsr_seed  = 32'h3418e48b;
    localparam logic [31:0] lfsr_taps  = 32'h80200003;     // x^32 + x^22 + x^2 + x + 1
    localparam int          wait_limit = 2000;             // cycles allowed per wait loop
    localparam pixel_t      color_a    = 24'h1f8c3a;
    localparam pixel_t      color_b    = 24'hd04a77;
    localparam pixel_t      color_c    = 24'h35b1e2;
    localparam pixel_t      color_d    = 24'hee0f0f;       // only reaches a zero width rect
    localparam pixel_t      color_e    = 24'h7a7a10;
    localparam pixel_t      color_f    = 24'h00ffc4;       // rejected command so never drawn

    logic      cpu_clk_g = 1'b0;
    logic      rst;
    logic      video_en;
    fill_cmd_t cmd;
    logic      cmd_valid;
    logic      cmd_ready;
    logic      fill_done;
    pixel_t    video;
    logic      video_valid;
    logic      video_ready;
    logic      frame_interrupt;

    logic [31:0] lfsr_q     = lfsr_seed;
    pixel_t      ref_pix [frame_w * frame_h];              // expected frame contents
    pixel_t      exp_pix;
    logic [5:0]  pix_idx;                                  // raster index of next transfer
    logic        xfer;
    logic        check_on   = 1'b0;                        // compare pixels with ref_pix
    logic        ready_rand = 1'b0;                        // ready from the lfsr
    logic        ready_hold = 1'b0;                        // ready level otherwise
    logic        busy;                                     // drawing fill in progress
    logic        pending;                                  // fill_done still owed
    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    always #20 cpu_clk_g = ~cpu_clk_g;

    video_subsys dut_i (
        .cpu_clk_g       (cpu_clk_g),
        .rst             (rst),
        .video_en        (video_en),
        .cmd             (cmd),
        .cmd_valid       (cmd_valid),
        .cmd_ready       (cmd_ready),
        .fill_done       (fill_done),
        .video           (video),
        .video_valid     (video_valid),
        .video_ready     (video_ready),
        .frame_interrupt (frame_interrupt)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    // lsb first, one step per bit
    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v[i]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic fill_cmd_t make_cmd(input logic [1:0] col0, input logic [2:0] row0,
                                           input logic [2:0] ncols, input logic [2:0] nrows,
                                           input pixel_t color);
        fill_cmd_t c;
        c.col0  = col0;
        c.row0  = row0;
        c.ncols = ncols;
        c.nrows = nrows;
        c.color = color;
        return c;
    endfunction

    function automatic logic has_area(input fill_cmd_t c);
        has_area = (c.ncols != 0) && (c.nrows != 0) && (c.row0 < frame_h);
    endfunction

    // clip to the frame edge, then paint whole words
    task automatic apply_fill(input fill_cmd_t c);
        int last_c;
        int last_r;
        int r;
        int px;
        if (has_area(c)) begin
            last_c = c.col0 + c.ncols - 1;
            last_r = c.row0 + c.nrows - 1;
            if (last_c > words_per_line - 1) last_c = words_per_line - 1;
            if (last_r > frame_h - 1) last_r = frame_h - 1;
            for (r = c.row0; r <= last_r; r++) begin
                for (px = c.col0 * pix_per_word; px < (last_c + 1) * pix_per_word; px++) begin
                    ref_pix[r * frame_w + px] = c.color;
                end
            end
        end
    endtask

    assign xfer    = video_valid && video_ready;
    assign exp_pix = ref_pix[pix_idx];

    always @(posedge cpu_clk_g) begin
        if (rst) begin
            pix_idx <= '0;
            busy    <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (xfer) pix_idx <= pix_idx + 1'b1;           // wraps by itself after 64 pixels
            if (cmd_valid && cmd_ready) begin
                pending <= 1'b1;
                busy    <= has_area(cmd);
            end else if (fill_done) begin
                pending <= 1'b0;
                busy    <= 1'b0;
            end
        end
    end

    reset_outputs: assert property (@(posedge cpu_clk_g)
        ((rst && $past(rst)) || $fell(rst)) |->
        ({video_valid, frame_interrupt, fill_done, cmd_ready} == 4'b0001))
    else begin
        errors++;
        $display("[FAIL] %0t {video_valid,frame_interrupt,fill_done,cmd_ready} exp 0001 got %b",
                 $time, {video_valid, frame_interrupt, fill_done, cmd_ready});
    end

    pixel_matches: assert property (@(posedge cpu_clk_g) disable iff (rst)
        (xfer && check_on) |-> (video == exp_pix))
    else begin
        errors++;
        $display("[FAIL] %0t video[%0d] expected %h got %h", $time, pix_idx, exp_pix, video);
    end

    irq_position: assert property (@(posedge cpu_clk_g) disable iff (rst)
        frame_interrupt == (xfer && (pix_idx == 6'd63)))
    else begin
        errors++;
        $display("[FAIL] %0t frame_interrupt expected %b got %b",
                 $time, xfer && (pix_idx == 6'd63), frame_interrupt);
    end

    valid_no_drop: assert property (@(posedge cpu_clk_g) disable iff (rst)
        $fell(video_valid) |-> $past(xfer))
    else begin
        errors++;
        $display("video_valid fell at %0t while its pixel was never taken", $time);
    end

    ready_low_busy: assert property (@(posedge cpu_clk_g) disable iff (rst)
        (busy && !fill_done) |-> !cmd_ready)
    else begin
        errors++;
        $display("[FAIL] %0t cmd_ready expected 0 got %b", $time, cmd_ready);
    end

    ready_on_done: assert property (@(posedge cpu_clk_g) disable iff (rst)
        fill_done |-> cmd_ready)
    else begin
        errors++;
        $display("[FAIL] %0t cmd_ready expected 1 got %b", $time, cmd_ready);
    end

    done_owed: assert property (@(posedge cpu_clk_g) disable iff (rst)
        fill_done |-> pending)
    else begin
        errors++;
        $display("fill_done at %0t with no accepted command outstanding", $time);
    end

    // inputs change 2 units past the rising edge
    task automatic step_cycle();
        @(posedge cpu_clk_g);
        #2;
    endtask

    task automatic send_cmd(input fill_cmd_t c);
        int n;
        step_cycle();
        cmd       = c;
        cmd_valid = 1'b1;
        n         = 0;
        while (!cmd_ready && n < wait_limit) begin
            step_cycle();
            n++;
        end
        if (cmd_ready) begin
            step_cycle();                                  // edge that accepts
            apply_fill(c);
        end else begin
            errors++;
            $display("timeout at %0t: cmd_ready stayed low", $time);
        end
        cmd_valid = 1'b0;
    endtask

    // valid offered while the engine is busy is ignored
    task automatic offer_while_busy(input fill_cmd_t c);
        cmd       = c;
        cmd_valid = 1'b1;
        step_cycle();
        step_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic wait_fill_done();
        int n;
        n = 0;
        do begin
            @(negedge cpu_clk_g);
            n++;
        end while (!fill_done && n < wait_limit);
        if (!fill_done) begin
            errors++;
            $display("timeout at %0t: fill_done never came", $time);
        end
    endtask

    // returns mid cycle while the last pixel waits for the next edge
    task automatic wait_frames(input int count);
        int f;
        int n;
        for (f = 0; f < count; f++) begin
            n = 0;
            do begin
                @(negedge cpu_clk_g);
                n++;
            end while (!frame_interrupt && n < wait_limit);
            if (!frame_interrupt) begin
                errors++;
                $display("timeout at %0t: frame_interrupt never came", $time);
            end
        end
    endtask

    // two boundaries flush words fetched before the fill
    task automatic check_frames(input int count);
        wait_frames(2);
        step_cycle();
        check_on = 1'b1;
        wait_frames(count);
        step_cycle();
        check_on = 1'b0;
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        if (errors > mark) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - mark);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        int          mark;
        logic [31:0] r;
        fill_cmd_t   c;
        rst       = 1'b1;
        video_en  = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        mark      = errors;                                // reset checks count from here
        repeat (10) @(posedge cpu_clk_g);
        #2;
        rst = 1'b0;
        step_cycle();
        step_cycle();
        report_test("reset state", mark);

        mark = errors;                                     // whole frame in colour a
        send_cmd(make_cmd(2'd0, 3'd0, 3'd4, 3'd4, color_a));
        wait_fill_done();
        check_on   = 1'b1;
        ready_hold = 1'b1;
        step_cycle();
        video_en = 1'b1;
        wait_frames(1);
        step_cycle();
        check_on = 1'b0;
        report_test("full frame fill", mark);

        mark = errors;                                     // random rect while streaming
        c.color = color_b;
        take_bits(2, r);
        c.col0 = r[1:0];
        take_bits(2, r);
        c.row0 = 3'(r[1:0]);                               // start inside the frame
        take_bits(2, r);
        c.ncols = 3'(r[1:0]) + 3'd1;                       // at least one word
        take_bits(2, r);
        c.nrows = 3'(r[1:0]) + 3'd1;                       // at least one line
        send_cmd(c);
        wait_fill_done();
        check_frames(1);
        report_test("concurrent fill", mark);

        mark = errors;
        send_cmd(make_cmd(2'd2, 3'd2, 3'd5, 3'd6, color_c));  // runs past both edges
        wait_fill_done();
        send_cmd(make_cmd(2'd0, 3'd0, 3'd0, 3'd3, color_d));  // no columns
        wait_fill_done();
        check_frames(1);
        report_test("clipping", mark);

        mark = errors;
        @(negedge cpu_clk_g);
        ready_rand = 1'b1;
        check_frames(3);
        @(negedge cpu_clk_g);
        ready_rand = 1'b0;
        report_test("back-pressure", mark);

        mark = errors;
        send_cmd(make_cmd(2'd1, 3'd1, 3'd2, 3'd2, color_e));
        offer_while_busy(make_cmd(2'd0, 3'd0, 3'd4, 3'd4, color_f));
        wait_fill_done();
        check_frames(1);
        report_test("command handshake", mark);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // video_ready held level or one lfsr bit per cycle
    initial begin
        logic [31:0] bit_v;
        video_ready = 1'b0;
        forever begin
            step_cycle();
            if (ready_rand) begin
                take_bits(1, bit_v);
                video_ready = bit_v[0];
            end else begin
                video_ready = ready_hold;
            end
        end
    end

endmodule
